/* src/tile_cfg_pkg.sv */
/*
 * counter width and counter types for the tile-loop controller
 */

package tile_cfg_pkg;

  // one width for element, inner-tile, tile and x/y counters
  localparam int unsigned CntW = 16;

  // in-flight count width well above any practical fifo depth
  localparam int unsigned OngoingW = 8;

  // counts, tile indexes and tile-count inputs
  typedef logic [CntW-1:0] counter_t;

  // completed-but-unread tiles
  typedef logic [OngoingW-1:0] ongoing_t;

endpackage

/* src/step_pkg.sv */
/*
 * layer request and step encodings
 */

package step_pkg;

  // layer requested with start
  typedef enum logic [1:0] {
    Linear      = 2'd0,  // single matmul
    Feedforward = 2'd1   // f1 then f2
  } layer_e;

  // step currently run by the tile loop
  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1,
    F1     = 2'd2,
    F2     = 2'd3
  } step_e;

endpackage

/* src/step_sequencer.sv */
/*
 * step FSM of the tile loop
 * forms inner limit, x limit and tile total for the running step
 */

module step_sequencer
  import step_pkg::*;
  import tile_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  layer_e   layer_i,
  input  counter_t tile_s_i,
  input  counter_t tile_e_i,
  input  counter_t tile_p_i,
  input  counter_t tile_f_i,
  input  logic     layer_done_i,
  output step_e    step_o,
  output counter_t inner_lim_o,
  output counter_t x_lim_o,
  output counter_t tiles_lim_o
);

  step_e    step_d, step_q;
  counter_t tiles_mult;  // column tiles of the current step

  assign step_o = step_q;

  always_comb begin
    step_d = step_q;
    case (step_q)
      Idle: begin
        if (start_i) begin  // start only counts here
          case (layer_i)
            Linear:      step_d = MatMul;
            Feedforward: step_d = F1;
            default:     step_d = Idle;
          endcase
        end
      end
      MatMul: begin
        if (layer_done_i) begin
          step_d = Idle;
        end
      end
      F1: begin
        if (layer_done_i) begin
          step_d = F2;  // second layer uses f1 results
        end
      end
      F2: begin
        if (layer_done_i) begin
          step_d = Idle;
        end
      end
      default: step_d = Idle;
    endcase
  end

  // loop limits stay zero in idle
  always_comb begin
    inner_lim_o = '0;
    x_lim_o     = '0;
    tiles_mult  = '0;
    case (step_q)
      MatMul: begin
        inner_lim_o = tile_e_i;
        tiles_mult  = tile_p_i;  // x/y not tracked
      end
      F1: begin
        inner_lim_o = tile_e_i;
        x_lim_o     = tile_f_i;
        tiles_mult  = tile_f_i;
      end
      F2: begin
        inner_lim_o = tile_f_i;
        x_lim_o     = tile_e_i;
        tiles_mult  = tile_e_i;
      end
      default: ;
    endcase
  end

  // single multiplier shared by all steps
  assign tiles_lim_o = tile_s_i * tiles_mult;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= Idle;
    end else begin
      step_q <= step_d;
    end
  end

endmodule

/* src/tile_counter.sv */
/*
 * element, inner-tile, tile and x/y position counters
 * flags the first and last inner tile and the final beat of a step
 */

module tile_counter
  import step_pkg::*;
  import tile_cfg_pkg::*;
#(
  parameter int unsigned M = 4,
  parameter int unsigned N = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  step_e    step_i,
  input  logic     beat_i,
  input  counter_t inner_lim_i,
  input  counter_t x_lim_i,
  input  counter_t tiles_lim_i,
  output counter_t inner_tile_o,
  output counter_t tile_x_o,
  output counter_t tile_y_o,
  output logic     first_inner_o,
  output logic     last_inner_o,
  output logic     layer_done_o
);

  localparam counter_t BeatsPerTile = counter_t'(M * M / N);

  counter_t count_d, count_q;
  counter_t inner_d, inner_q;
  counter_t tile_d, tile_q;
  counter_t x_d, x_q;
  counter_t y_d, y_q;

  counter_t inner_end, x_end, tiles_end;
  logic     elem_wrap, inner_wrap, x_wrap;

  assign inner_end = inner_lim_i - 1'b1;  // all ones in idle
  assign x_end     = x_lim_i - 1'b1;
  assign tiles_end = tiles_lim_i - 1'b1;

  assign elem_wrap    = beat_i && (count_q == BeatsPerTile - 1'b1);
  assign inner_wrap   = elem_wrap && (inner_q == inner_end);
  assign x_wrap       = x_q == x_end;
  assign layer_done_o = inner_wrap && (tile_q == tiles_end);

  assign inner_tile_o  = inner_q;
  assign tile_x_o      = x_q;
  assign tile_y_o      = y_q;
  assign first_inner_o = inner_q == '0;
  assign last_inner_o  = inner_q == inner_end;

  always_comb begin
    count_d = count_q;
    inner_d = inner_q;
    tile_d  = tile_q;
    x_d     = x_q;
    y_d     = y_q;
    if (step_i == Idle) begin
      count_d = '0;
      inner_d = '0;
      tile_d  = '0;
      x_d     = '0;
      y_d     = '0;
    end else if (beat_i) begin
      count_d = elem_wrap ? '0 : count_q + 1'b1;
      if (elem_wrap) begin
        inner_d = inner_q + 1'b1;
      end
      if (inner_wrap) begin  // output tile complete
        inner_d = '0;
        tile_d  = tile_q + 1'b1;
        if (x_lim_i != '0) begin  // matmul keeps x/y at 0
          x_d = x_wrap ? '0 : x_q + 1'b1;
          y_d = x_wrap ? y_q + 1'b1 : y_q;
        end
      end
      if (layer_done_o) begin  // next step starts from origin
        tile_d = '0;
        x_d    = '0;
        y_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      inner_q <= '0;
      tile_q  <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else begin
      count_q <= count_d;
      inner_q <= inner_d;
      tile_q  <= tile_d;
      x_q     <= x_d;
      y_q     <= y_d;
    end
  end

endmodule

/* src/issue_gate.sv */
/*
 * operand issue gate with in-flight tile limit
 * drives the operand readies, the beat strobe and calc enable
 */

module issue_gate
  import step_pkg::*;
  import tile_cfg_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  step_e step_i,
  input  logic  inp_valid_i,
  input  logic  weight_valid_i,
  input  logic  bias_valid_i,
  input  logic  oup_valid_i,
  input  logic  oup_ready_i,
  input  logic  last_inner_i,
  output logic  inp_ready_o,
  output logic  weight_ready_o,
  output logic  bias_ready_o,
  output logic  calc_en_o,
  output logic  beat_o
);

  ongoing_t ongoing_d, ongoing_q;  // tiles waiting to be read out
  logic     gate_open;
  logic     all_valid;
  logic     oup_hs;
  logic     tile_beat;

  assign gate_open = (step_i != Idle) && (ongoing_q < FifoDepth);
  assign all_valid = inp_valid_i && weight_valid_i && bias_valid_i;

  // readies cross-coupled to the other operand valid
  assign inp_ready_o    = gate_open && weight_valid_i;
  assign weight_ready_o = gate_open && inp_valid_i;
  assign bias_ready_o   = gate_open && weight_valid_i;

  assign beat_o    = gate_open && all_valid;
  assign calc_en_o = beat_o;

  assign oup_hs    = oup_valid_i && oup_ready_i;
  assign tile_beat = beat_o && last_inner_i;  // beat feeding the output fifo

  always_comb begin
    ongoing_d = ongoing_q;
    if (tile_beat && !oup_hs) begin
      ongoing_d = ongoing_q + 1'b1;
    end else if (oup_hs && !tile_beat) begin
      ongoing_d = ongoing_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q <= '0;
    end else begin
      ongoing_q <= ongoing_d;
    end
  end

endmodule

/* src/tile_ctrl_top.sv */
/*
 * tile-loop controller top with step FSM, tile counters and issue gate
 */

module tile_ctrl_top
  import step_pkg::*;
  import tile_cfg_pkg::*;
#(
  parameter int unsigned M         = 4,
  parameter int unsigned N         = 4,
  parameter int unsigned FifoDepth = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  layer_e   layer_i,
  input  counter_t tile_s_i,
  input  counter_t tile_e_i,
  input  counter_t tile_p_i,
  input  counter_t tile_f_i,
  input  logic     inp_valid_i,
  output logic     inp_ready_o,
  input  logic     weight_valid_i,
  output logic     weight_ready_o,
  input  logic     bias_valid_i,
  output logic     bias_ready_o,
  input  logic     oup_valid_i,
  input  logic     oup_ready_i,
  output logic     calc_en_o,
  output step_e    step_o,
  output logic     first_inner_tile_o,
  output logic     last_inner_tile_o,
  output counter_t tile_x_o,
  output counter_t tile_y_o,
  output counter_t inner_tile_o,
  output logic     busy_o
);

  counter_t inner_lim, x_lim, tiles_lim;
  logic     layer_done;
  logic     beat;

  assign busy_o = step_o != Idle;

  step_sequencer u_step_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .layer_i      (layer_i),
    .tile_s_i     (tile_s_i),
    .tile_e_i     (tile_e_i),
    .tile_p_i     (tile_p_i),
    .tile_f_i     (tile_f_i),
    .layer_done_i (layer_done),
    .step_o       (step_o),
    .inner_lim_o  (inner_lim),
    .x_lim_o      (x_lim),
    .tiles_lim_o  (tiles_lim)
  );

  tile_counter #(
    .M (M),
    .N (N)
  ) u_tile_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .step_i        (step_o),
    .beat_i        (beat),
    .inner_lim_i   (inner_lim),
    .x_lim_i       (x_lim),
    .tiles_lim_i   (tiles_lim),
    .inner_tile_o  (inner_tile_o),
    .tile_x_o      (tile_x_o),
    .tile_y_o      (tile_y_o),
    .first_inner_o (first_inner_tile_o),
    .last_inner_o  (last_inner_tile_o),
    .layer_done_o  (layer_done)
  );

  issue_gate #(
    .FifoDepth (FifoDepth)
  ) u_issue_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .step_i         (step_o),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .last_inner_i   (last_inner_tile_o),  // tiles in the last inner pass fill the fifo
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en_o),
    .beat_o         (beat)
  );

endmodule

/* test/clk_gen.sv */
/*
 * testbench clock and active-low reset source
 */

module clk_gen #(
  parameter int Period      = 20,
  parameter int ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);  // release away from the active edge
    rst_no = 1'b1;
  end

endmodule

/* test/tile_ctrl_props.sv */
/*
 * concurrent checks bound into the issue gate
 */

module tile_ctrl_props
  import step_pkg::*;
  import tile_cfg_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input logic     clk_i,
  input logic     rst_ni,
  input step_e    step_i,
  input logic     inp_valid_i,
  input logic     weight_valid_i,
  input logic     bias_valid_i,
  input logic     inp_ready_i,
  input logic     weight_ready_i,
  input logic     bias_ready_i,
  input logic     calc_en_i,
  input ongoing_t ongoing_i
);

  int unsigned fail_count = 0;  // read by the testbench at the end

  idle_no_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i == Idle |-> !(inp_ready_i || weight_ready_i || bias_ready_i))
    else begin
      fail_count++;
      $error("operand ready high while idle");
    end

  calc_needs_valids: assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> (inp_valid_i && weight_valid_i && bias_valid_i))
    else begin
      fail_count++;
      $error("calc enable without all operand valids");
    end

  ongoing_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ongoing_i <= FifoDepth)
    else begin
      fail_count++;
      $error("in-flight tile count above fifo depth");
    end

endmodule

bind issue_gate tile_ctrl_props #(
  .FifoDepth (FifoDepth)
) u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .step_i         (step_i),
  .inp_valid_i    (inp_valid_i),
  .weight_valid_i (weight_valid_i),
  .bias_valid_i   (bias_valid_i),
  .inp_ready_i    (inp_ready_o),
  .weight_ready_i (weight_ready_o),
  .bias_ready_i   (bias_ready_o),
  .calc_en_i      (calc_en_o),
  .ongoing_i      (ongoing_q)
);

/* test/tb_tile_ctrl.sv */
/*
 * testbench for tile_ctrl_top with a row table applied in a loop
 * reference model of step, tile position and in-flight count plus a cycle timeout
 */

module tb_tile_ctrl
  import step_pkg::*;
  import tile_cfg_pkg::*;
();

  localparam int M            = 4;
  localparam int N            = 4;
  localparam int FifoDepth    = 2;
  localparam int BeatsPerTile = M * M / N;
  localparam int NumRows      = 6;

  typedef struct packed {
    layer_e layer;
    int     s;
    int     e;
    int     p;
    int     f;
    bit     rnd;    // random operand valids
    int     stall;  // cycles of oup_ready low after start
  } row_t;

  logic     clk, rst_n, start;
  logic     inp_valid, weight_valid, bias_valid, oup_valid, oup_ready;
  logic     inp_ready, weight_ready, bias_ready, calc_en;
  logic     first_inner, last_inner, busy;
  layer_e   layer;
  step_e    step;
  counter_t tile_s, tile_e, tile_p, tile_f;
  counter_t tile_x, tile_y, inner_tile;

  row_t  rows [NumRows];
  step_e m_step = Idle;
  int    m_cnt = 0, m_inner = 0, m_tile = 0, m_x = 0, m_y = 0, m_ongoing = 0;
  int    step_calc = 0, row_calc = 0, closed_cycles = 0;
  int    cycles = 0, limit = 0;

  clk_gen #(.Period(20), .ResetCycles(5)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  tile_ctrl_top #(.M(M), .N(N), .FifoDepth(FifoDepth)) DUT (
    .clk_i (clk), .rst_ni (rst_n), .start_i (start), .layer_i (layer),
    .tile_s_i (tile_s), .tile_e_i (tile_e), .tile_p_i (tile_p), .tile_f_i (tile_f),
    .inp_valid_i (inp_valid), .inp_ready_o (inp_ready),
    .weight_valid_i (weight_valid), .weight_ready_o (weight_ready),
    .bias_valid_i (bias_valid), .bias_ready_o (bias_ready),
    .oup_valid_i (oup_valid), .oup_ready_i (oup_ready), .calc_en_o (calc_en),
    .step_o (step), .first_inner_tile_o (first_inner), .last_inner_tile_o (last_inner),
    .tile_x_o (tile_x), .tile_y_o (tile_y), .inner_tile_o (inner_tile), .busy_o (busy)
  );

  task automatic expect_equal(input int got, input int exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  function automatic int inner_limit(step_e s, row_t r);
    case (s)
      MatMul, F1: return r.e;
      F2:         return r.f;
      default:    return 0;
    endcase
  endfunction

  function automatic int x_limit(step_e s, row_t r);
    case (s)
      F1:      return r.f;
      F2:      return r.e;
      default: return 0;  // matmul has no x/y walk
    endcase
  endfunction

  function automatic int tile_total(step_e s, row_t r);
    case (s)
      MatMul:  return r.s * r.p;
      F1:      return r.s * r.f;
      F2:      return r.s * r.e;
      default: return 0;
    endcase
  endfunction

  function automatic int row_beats(row_t r);
    if (r.layer == Linear) return BeatsPerTile * r.e * r.s * r.p;
    return BeatsPerTile * (r.e * r.s * r.f + r.f * r.s * r.e);
  endfunction

  // drive at the falling edge, check, then advance the model
  task automatic run_cycle(input row_t r, input int rc, input logic go);
    int   il, xl, tl;
    logic open, beat, at_last, hs;
    @(negedge clk);
    start  = go;
    layer  = r.layer;
    tile_s = counter_t'(r.s);
    tile_e = counter_t'(r.e);
    tile_p = counter_t'(r.p);
    tile_f = counter_t'(r.f);
    if (r.rnd) begin
      inp_valid    = ($urandom % 4) != 0;
      weight_valid = ($urandom % 4) != 0;
      bias_valid   = ($urandom % 4) != 0;
    end else begin
      inp_valid    = 1'b1;
      weight_valid = 1'b1;
      bias_valid   = 1'b1;
    end
    oup_valid = m_ongoing > 0;  // fifo has a tile to hand out
    oup_ready = (r.stall == 0) || ((rc >= r.stall) && (rc % 2 == 1));
    #1;
    il      = inner_limit(m_step, r);
    xl      = x_limit(m_step, r);
    tl      = tile_total(m_step, r);
    open    = (m_step != Idle) && (m_ongoing < FifoDepth);
    beat    = open && inp_valid && weight_valid && bias_valid;
    at_last = m_inner == il - 1;
    hs      = oup_valid && oup_ready;
    expect_equal(int'(step), int'(m_step), "step_o");
    expect_equal(int'(busy), int'(m_step != Idle), "busy_o");
    expect_equal(int'(inp_ready), int'(open && weight_valid), "inp_ready_o");
    expect_equal(int'(weight_ready), int'(open && inp_valid), "weight_ready_o");
    expect_equal(int'(bias_ready), int'(open && weight_valid), "bias_ready_o");
    expect_equal(int'(calc_en), int'(beat), "calc_en_o");
    expect_equal(int'(tile_x), m_x, "tile_x_o");
    expect_equal(int'(tile_y), m_y, "tile_y_o");
    if (m_step != Idle) begin
      expect_equal(int'(inner_tile), m_inner, "inner_tile_o");
      expect_equal(int'(first_inner), int'(m_inner == 0), "first_inner_tile_o");
      expect_equal(int'(last_inner), int'(at_last), "last_inner_tile_o");
      if (!open) closed_cycles++;
    end
    if (calc_en) begin
      step_calc++;
      row_calc++;
    end
    if (beat && at_last && !hs) m_ongoing++;
    else if (hs && !(beat && at_last)) m_ongoing--;
    if (m_step == Idle) begin
      if (go) m_step = (r.layer == Linear) ? MatMul : F1;
    end else if (beat) begin
      m_cnt++;
      if (m_cnt == BeatsPerTile) begin
        m_cnt = 0;
        m_inner++;
        if (m_inner == il) begin  // output tile done
          m_inner = 0;
          m_tile++;
          if (xl != 0) begin
            m_x++;
            if (m_x == xl) begin
              m_x = 0;
              m_y++;
            end
          end
          if (m_tile == tl) begin
            expect_equal(step_calc, BeatsPerTile * il * tl, "calc_en pulses in step");
            step_calc = 0;
            m_tile    = 0;
            m_x       = 0;
            m_y       = 0;
            m_step    = (m_step == F1) ? F2 : Idle;
          end
        end
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    int rc;
    rc            = 0;
    row_calc      = 0;
    step_calc     = 0;
    closed_cycles = 0;
    run_cycle(r, rc, 1'b1);
    while (m_step != Idle || m_ongoing > 0) begin  // run and drain the fifo
      rc++;
      run_cycle(r, rc, 1'b0);
    end
    expect_equal(row_calc, row_beats(r), "calc_en pulses in layer");
    if (r.stall > 0) expect_equal(int'(closed_cycles > 0), 1, "gate closed under stall");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the controller did not finish within %0d cycles", limit);
      $display("tests failed");
      $fatal(1);
    end
  end

  initial begin
    start        = 1'b0;
    layer        = Linear;
    tile_s       = '0;
    tile_e       = '0;
    tile_p       = '0;
    tile_f       = '0;
    inp_valid    = 1'b0;
    weight_valid = 1'b0;
    bias_valid   = 1'b0;
    oup_valid    = 1'b0;
    oup_ready    = 1'b0;
    void'($urandom(32'ha6b0_09a2));
    rows[0] = '{Linear,      1, 2, 2, 0, 1'b0, 0};
    rows[1] = '{Feedforward, 1, 2, 0, 3, 1'b0, 0};
    rows[2] = '{Linear,      2, 1, 3, 0, 1'b1, 0};
    rows[3] = '{Feedforward, 2, 2, 0, 2, 1'b1, 0};
    rows[4] = '{Linear,      1, 3, 2, 0, 1'b0, 16};
    rows[5] = '{Feedforward, 1, 1, 0, 2, 1'b0, 8};
    limit = 200;
    for (int i = 0; i < NumRows; i++) limit += 4 * row_beats(rows[i]);
    repeat (8) run_cycle(rows[0], 0, 1'b0);  // reset and idle with all valids high
    for (int i = 0; i < NumRows; i++) apply_row(rows[i]);
    expect_equal(int'(DUT.u_issue_gate.u_props.fail_count), 0, "property failures");
    $display("all tests passed");
    $finish;
  end

endmodule

/* project.f */
src/tile_cfg_pkg.sv
src/step_pkg.sv
src/step_sequencer.sv
src/tile_counter.sv
src/issue_gate.sv
src/tile_ctrl_top.sv
test/clk_gen.sv
test/tile_ctrl_props.sv
test/tb_tile_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the tile-loop controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_tile_ctrl

out=$(./obj_dir/Vtb_tile_ctrl 2>&1) || true
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
  exit 0
fi
exit 1
